// ==== rtl/zynq_addr_pkg.sv ====
package zynq_addr_pkg;

   // the PS host window drops the top two address bits
   localparam int host_addr_width = 30;
   localparam int core_addr_width = 32;

   // core cached DRAM starts at this bit, PS DRAM starts at the allocated base
   localparam logic [core_addr_width-1:0] dram_base_flip = 32'h8000_0000;

   // core outbound writes below this address go to the host mailbox
   localparam logic [core_addr_width-1:0] io_split_addr = 32'h0020_0000;

   // one profiler bit per 8 MB page of core address space
   localparam int profile_pages = 128;
   localparam int page_width = $clog2(profile_pages);

   typedef struct packed {
      logic [1:0]            region;
      logic [page_width-1:0] page;
      logic [22:0]           offset;
   } core_addr_fields_s;

   // the same core address seen as a number or split into its fields
   typedef union packed {
      logic [core_addr_width-1:0] word;
      core_addr_fields_s          f;
   } core_addr_u;

endpackage

// ==== rtl/zynq_csr_pkg.sv ====
package zynq_csr_pkg;

   localparam int csr_data_width = 32;
   localparam int csr_idx_width = 4;

   // read/write control registers
   localparam logic [csr_idx_width-1:0] csr_ctrl_idx = 4'd0;
   localparam logic [csr_idx_width-1:0] csr_alloc_idx = 4'd1;
   localparam logic [csr_idx_width-1:0] csr_base_idx = 4'd2;

   // profiler map, lowest page bits first
   localparam logic [csr_idx_width-1:0] csr_prof0_idx = 4'd3;
   localparam logic [csr_idx_width-1:0] csr_prof1_idx = 4'd4;
   localparam logic [csr_idx_width-1:0] csr_prof2_idx = 4'd5;
   localparam logic [csr_idx_width-1:0] csr_prof3_idx = 4'd6;

   // mailbox status and the head word, reading the head pops it
   localparam logic [csr_idx_width-1:0] csr_mbox_count_idx = 4'd7;
   localparam logic [csr_idx_width-1:0] csr_mbox_pop_idx = 4'd8;

endpackage

// ==== rtl/zynq_csr_bank.sv ====
`timescale 1ns/1ps

module zynq_csr_bank
   (input  logic                                      clk_i
   ,input  logic                                      rst_n_i
   ,input  logic                                      csr_valid_i
   ,output logic                                      csr_ready_o
   ,input  logic                                      csr_we_i
   ,input  logic [zynq_csr_pkg::csr_idx_width-1:0]    csr_idx_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]   csr_wdata_i
   ,output logic                                      csr_rvalid_o
   ,input  logic                                      csr_rready_i
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]   csr_rdata_o
   ,input  logic [zynq_addr_pkg::profile_pages-1:0]   prof_map_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]   mbox_count_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]   mbox_data_i
   ,output logic                                      mbox_pop_o
   ,output logic                                      core_run_o
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]   dram_base_o
   );

   import zynq_csr_pkg::*;

   logic [csr_data_width-1:0] ctrl_r;
   logic [csr_data_width-1:0] alloc_r;
   logic [csr_data_width-1:0] base_r;
   logic [csr_data_width-1:0] read_word;
   logic                      req_fire;

   // one request in flight, the next one waits until the response is taken
   assign csr_ready_o = ~csr_rvalid_o;
   assign req_fire = csr_valid_i & csr_ready_o;

   assign mbox_pop_o = req_fire & ~csr_we_i & (csr_idx_i == csr_mbox_pop_idx);
   assign core_run_o = ctrl_r[0];
   assign dram_base_o = base_r;

   always_comb
   begin
      case (csr_idx_i)
         csr_ctrl_idx:       read_word = ctrl_r;
         csr_alloc_idx:      read_word = alloc_r;
         csr_base_idx:       read_word = base_r;
         csr_prof0_idx:      read_word = prof_map_i[0*csr_data_width +: csr_data_width];
         csr_prof1_idx:      read_word = prof_map_i[1*csr_data_width +: csr_data_width];
         csr_prof2_idx:      read_word = prof_map_i[2*csr_data_width +: csr_data_width];
         csr_prof3_idx:      read_word = prof_map_i[3*csr_data_width +: csr_data_width];
         csr_mbox_count_idx: read_word = mbox_count_i;
         // the mailbox drives zero when empty, so an empty pop reads zero
         csr_mbox_pop_idx:   read_word = mbox_data_i;
         default:            read_word = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ctrl_r <= '0;
         alloc_r <= '0;
         base_r <= '0;
         csr_rvalid_o <= 1'b0;
      end
      else
      begin
         if (req_fire)
            csr_rvalid_o <= 1'b1;
         else if (csr_rready_i)
            csr_rvalid_o <= 1'b0;

         // writes to the read-only indices fall through here
         if (req_fire && csr_we_i)
         begin
            case (csr_idx_i)
               csr_ctrl_idx:  ctrl_r <= csr_wdata_i;
               csr_alloc_idx: alloc_r <= csr_wdata_i;
               csr_base_idx:  base_r <= csr_wdata_i;
               default:       ;
            endcase
         end
      end
   end

   // a write answers with zero
   always_ff @(posedge clk_i)
   begin
      if (req_fire)
         csr_rdata_o <= csr_we_i ? '0 : read_word;
   end

endmodule

// ==== rtl/host_addr_xlate.sv ====
`timescale 1ns/1ps

module host_addr_xlate
   (input  logic                                       clk_i
   ,input  logic                                       rst_n_i
   ,input  logic                                       host_valid_i
   ,output logic                                       host_ready_o
   ,input  logic [zynq_addr_pkg::host_addr_width-1:0]  host_addr_i
   ,input  logic                                       host_we_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]    host_wdata_i
   ,output logic                                       core_valid_o
   ,input  logic                                       core_ready_i
   ,output logic [zynq_addr_pkg::core_addr_width-1:0]  core_addr_o
   ,output logic                                       core_we_o
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    core_wdata_o
   );

   import zynq_addr_pkg::*;

   logic [core_addr_width-1:0] xlate_addr;
   logic                       in_fire;

   // window bit clear selects cached DRAM at 0x8000_0000, set selects local space at 0
   assign xlate_addr = {~host_addr_i[host_addr_width-1], 3'b000, host_addr_i[27:0]};

   assign host_ready_o = ~core_valid_o | core_ready_i;
   assign in_fire = host_valid_i & host_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         core_valid_o <= 1'b0;
      else if (host_ready_o)
         core_valid_o <= host_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (in_fire)
      begin
         core_addr_o <= xlate_addr;
         core_we_o <= host_we_i;
         core_wdata_o <= host_wdata_i;
      end
   end

endmodule

// ==== rtl/dram_addr_xlate.sv ====
`timescale 1ns/1ps

module dram_addr_xlate
   (input  logic                                       clk_i
   ,input  logic                                       rst_n_i
   ,input  logic                                       dram_req_valid_i
   ,output logic                                       dram_req_ready_o
   ,input  logic [zynq_addr_pkg::core_addr_width-1:0]  dram_req_addr_i
   ,input  logic                                       dram_req_we_i
   ,input  logic [zynq_addr_pkg::core_addr_width-1:0]  dram_base_i
   ,output logic                                       dram_valid_o
   ,input  logic                                       dram_ready_i
   ,output logic [zynq_addr_pkg::core_addr_width-1:0]  dram_addr_o
   ,output logic                                       dram_we_o
   ,output logic                                       dram_req_fire_o
   ,output logic [zynq_addr_pkg::page_width-1:0]       dram_req_page_o
   );

   import zynq_addr_pkg::*;

   core_addr_u                 req_addr;
   logic [core_addr_width-1:0] xlate_addr;

   assign req_addr = dram_req_addr_i;

   // strip the core DRAM base bit and rebase onto the buffer the host allocated
   assign xlate_addr = (req_addr.word ^ dram_base_flip) + dram_base_i;

   assign dram_req_ready_o = ~dram_valid_o | dram_ready_i;
   assign dram_req_fire_o = dram_req_valid_i & dram_req_ready_o;

   // the profiler sees the untranslated core page
   assign dram_req_page_o = req_addr.f.page;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         dram_valid_o <= 1'b0;
      else if (dram_req_ready_o)
         dram_valid_o <= dram_req_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (dram_req_fire_o)
      begin
         dram_addr_o <= xlate_addr;
         dram_we_o <= dram_req_we_i;
      end
   end

endmodule

// ==== rtl/mem_profiler.sv ====
`timescale 1ns/1ps

module mem_profiler
   (input  logic                                     clk_i
   ,input  logic                                     core_rst_n_i
   ,input  logic                                     fire_i
   ,input  logic [zynq_addr_pkg::page_width-1:0]     page_i
   ,output logic [zynq_addr_pkg::profile_pages-1:0]  prof_map_o
   );

   import zynq_addr_pkg::*;

   logic [profile_pages-1:0] touch_bit;

   assign touch_bit = fire_i ? (profile_pages'(1) << page_i) : '0;

   // the map restarts with every core reset, so each run is profiled on its own
   always_ff @(posedge clk_i)
   begin
      if (!core_rst_n_i)
         prof_map_o <= '0;
      else
         prof_map_o <= prof_map_o | touch_bit;
   end

endmodule

// ==== rtl/core_io_router.sv ====
`timescale 1ns/1ps

module core_io_router
   #(parameter int mailbox_depth_p = 8)
   (input  logic                                       clk_i
   ,input  logic                                       rst_n_i
   ,input  logic                                       io_valid_i
   ,output logic                                       io_ready_o
   ,input  logic [zynq_addr_pkg::core_addr_width-1:0]  io_addr_i
   ,input  logic                                       io_we_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]    io_wdata_i
   ,output logic                                       mmio_valid_o
   ,input  logic                                       mmio_ready_i
   ,output logic [zynq_addr_pkg::core_addr_width-1:0]  mmio_addr_o
   ,output logic                                       mmio_we_o
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    mmio_wdata_o
   ,input  logic                                       mbox_pop_i
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    mbox_count_o
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    mbox_data_o
   );

   import zynq_addr_pkg::*;
   import zynq_csr_pkg::*;

   localparam int ptr_width_lp = (mailbox_depth_p > 1) ? $clog2(mailbox_depth_p) : 1;
   localparam int cnt_width_lp = $clog2(mailbox_depth_p + 1);

   logic [csr_data_width-1:0] mbox_mem [mailbox_depth_p];
   logic [ptr_width_lp-1:0]   wr_ptr_r;
   logic [ptr_width_lp-1:0]   rd_ptr_r;
   logic [cnt_width_lp-1:0]   count_r;
   logic                      to_mbox;
   logic                      mbox_full;
   logic                      mbox_empty;
   logic                      push;
   logic                      pop;

   // only stores into the low host space are packed for the host, reads pass through
   assign to_mbox = io_we_i & (io_addr_i < io_split_addr);
   assign mbox_full = (count_r == cnt_width_lp'(mailbox_depth_p));
   assign mbox_empty = (count_r == '0);

   assign io_ready_o = to_mbox ? ~mbox_full : mmio_ready_i;
   assign mmio_valid_o = io_valid_i & ~to_mbox;
   assign mmio_addr_o = io_addr_i;
   assign mmio_we_o = io_we_i;
   assign mmio_wdata_o = io_wdata_i;

   assign push = io_valid_i & to_mbox & ~mbox_full;
   assign pop = mbox_pop_i & ~mbox_empty;

   assign mbox_count_o = csr_data_width'(count_r);
   assign mbox_data_o = mbox_empty ? '0 : mbox_mem[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r <= '0;
      end
      else
      begin
         // pointers wrap by compare so any depth works
         if (push)
            wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(mailbox_depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(mailbox_depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         count_r <= count_r + cnt_width_lp'(push) - cnt_width_lp'(pop);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
         mbox_mem[wr_ptr_r] <= io_wdata_i;
   end

endmodule

// ==== rtl/bp_zynq_bridge.sv ====
`timescale 1ns/1ps

module bp_zynq_bridge
   #(parameter int mailbox_depth_p = 8)
   (input  logic                                       clk_i
   ,input  logic                                       rst_n_i
   ,output logic                                       core_rst_n_o
   ,input  logic                                       csr_valid_i
   ,output logic                                       csr_ready_o
   ,input  logic                                       csr_we_i
   ,input  logic [zynq_csr_pkg::csr_idx_width-1:0]     csr_idx_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]    csr_wdata_i
   ,output logic                                       csr_rvalid_o
   ,input  logic                                       csr_rready_i
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    csr_rdata_o
   ,input  logic                                       host_valid_i
   ,output logic                                       host_ready_o
   ,input  logic [zynq_addr_pkg::host_addr_width-1:0]  host_addr_i
   ,input  logic                                       host_we_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]    host_wdata_i
   ,output logic                                       core_valid_o
   ,input  logic                                       core_ready_i
   ,output logic [zynq_addr_pkg::core_addr_width-1:0]  core_addr_o
   ,output logic                                       core_we_o
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    core_wdata_o
   ,input  logic                                       dram_req_valid_i
   ,output logic                                       dram_req_ready_o
   ,input  logic [zynq_addr_pkg::core_addr_width-1:0]  dram_req_addr_i
   ,input  logic                                       dram_req_we_i
   ,output logic                                       dram_valid_o
   ,input  logic                                       dram_ready_i
   ,output logic [zynq_addr_pkg::core_addr_width-1:0]  dram_addr_o
   ,output logic                                       dram_we_o
   ,input  logic                                       io_valid_i
   ,output logic                                       io_ready_o
   ,input  logic [zynq_addr_pkg::core_addr_width-1:0]  io_addr_i
   ,input  logic                                       io_we_i
   ,input  logic [zynq_csr_pkg::csr_data_width-1:0]    io_wdata_i
   ,output logic                                       mmio_valid_o
   ,input  logic                                       mmio_ready_i
   ,output logic [zynq_addr_pkg::core_addr_width-1:0]  mmio_addr_o
   ,output logic                                       mmio_we_o
   ,output logic [zynq_csr_pkg::csr_data_width-1:0]    mmio_wdata_o
   );

   import zynq_addr_pkg::*;
   import zynq_csr_pkg::*;

   logic                      core_run;
   logic [csr_data_width-1:0] dram_base;
   logic [profile_pages-1:0]  prof_map;
   logic [csr_data_width-1:0] mbox_count;
   logic [csr_data_width-1:0] mbox_data;
   logic                      mbox_pop;
   logic                      dram_req_fire;
   logic [page_width-1:0]     dram_req_page;

   // the host can rerun the core without a full bridge reset
   assign core_rst_n_o = rst_n_i & core_run;

   zynq_csr_bank u_csr_bank
      (.clk_i(clk_i), .rst_n_i(rst_n_i)
      ,.csr_valid_i(csr_valid_i), .csr_ready_o(csr_ready_o), .csr_we_i(csr_we_i)
      ,.csr_idx_i(csr_idx_i), .csr_wdata_i(csr_wdata_i)
      ,.csr_rvalid_o(csr_rvalid_o), .csr_rready_i(csr_rready_i), .csr_rdata_o(csr_rdata_o)
      ,.prof_map_i(prof_map), .mbox_count_i(mbox_count), .mbox_data_i(mbox_data)
      ,.mbox_pop_o(mbox_pop), .core_run_o(core_run), .dram_base_o(dram_base)
      );

   host_addr_xlate u_host_xlate
      (.clk_i(clk_i), .rst_n_i(rst_n_i)
      ,.host_valid_i(host_valid_i), .host_ready_o(host_ready_o), .host_addr_i(host_addr_i)
      ,.host_we_i(host_we_i), .host_wdata_i(host_wdata_i)
      ,.core_valid_o(core_valid_o), .core_ready_i(core_ready_i), .core_addr_o(core_addr_o)
      ,.core_we_o(core_we_o), .core_wdata_o(core_wdata_o)
      );

   dram_addr_xlate u_dram_xlate
      (.clk_i(clk_i), .rst_n_i(rst_n_i)
      ,.dram_req_valid_i(dram_req_valid_i), .dram_req_ready_o(dram_req_ready_o)
      ,.dram_req_addr_i(dram_req_addr_i), .dram_req_we_i(dram_req_we_i)
      ,.dram_base_i(dram_base)
      ,.dram_valid_o(dram_valid_o), .dram_ready_i(dram_ready_i)
      ,.dram_addr_o(dram_addr_o), .dram_we_o(dram_we_o)
      ,.dram_req_fire_o(dram_req_fire), .dram_req_page_o(dram_req_page)
      );

   mem_profiler u_profiler
      (.clk_i(clk_i), .core_rst_n_i(core_rst_n_o)
      ,.fire_i(dram_req_fire), .page_i(dram_req_page), .prof_map_o(prof_map)
      );

   core_io_router #(.mailbox_depth_p(mailbox_depth_p)) u_io_router
      (.clk_i(clk_i), .rst_n_i(rst_n_i)
      ,.io_valid_i(io_valid_i), .io_ready_o(io_ready_o), .io_addr_i(io_addr_i)
      ,.io_we_i(io_we_i), .io_wdata_i(io_wdata_i)
      ,.mmio_valid_o(mmio_valid_o), .mmio_ready_i(mmio_ready_i), .mmio_addr_o(mmio_addr_o)
      ,.mmio_we_o(mmio_we_o), .mmio_wdata_o(mmio_wdata_o)
      ,.mbox_pop_i(mbox_pop), .mbox_count_o(mbox_count), .mbox_data_o(mbox_data)
      );

endmodule

// ==== dv/tb_bp_zynq_bridge.sv ====
`timescale 1ns/1ps

module tb_bp_zynq_bridge;

   localparam int mbox_depth = 8;
   localparam int n_csr = 40;
   localparam int n_host = 60;
   localparam int n_dram = 60;
   localparam int n_io_rounds = 6;
   // register accesses outside the random loops
   localparam int n_fixed = 20;
   localparam int n_total = n_fixed + n_csr + n_host + n_dram
                            + n_io_rounds * (2 * mbox_depth + 3);
   // every transaction gets 40 cycles of 40 ns
   localparam longint timeout_ns = longint'(n_total) * 40 * 40;

   // DUT inputs start idle
   logic        clk_i = 1'b0;
   logic        rst_n_i = 1'b0;
   logic        csr_valid_i = 1'b0, csr_we_i = 1'b0, csr_rready_i = 1'b0;
   logic [3:0]  csr_idx_i = '0;
   logic [31:0] csr_wdata_i = '0;
   logic        host_valid_i = 1'b0, host_we_i = 1'b0, core_ready_i = 1'b0;
   logic [29:0] host_addr_i = '0;
   logic [31:0] host_wdata_i = '0;
   logic        dram_req_valid_i = 1'b0, dram_req_we_i = 1'b0, dram_ready_i = 1'b0;
   logic [31:0] dram_req_addr_i = '0;
   logic        io_valid_i = 1'b0, io_we_i = 1'b0, mmio_ready_i = 1'b0;
   logic [31:0] io_addr_i = '0, io_wdata_i = '0;

   logic        core_rst_n_o, csr_ready_o, csr_rvalid_o, host_ready_o, core_valid_o, core_we_o;
   logic        dram_req_ready_o, dram_valid_o, dram_we_o, io_ready_o, mmio_valid_o, mmio_we_o;
   logic [31:0] csr_rdata_o, core_addr_o, core_wdata_o, dram_addr_o, mmio_addr_o, mmio_wdata_o;

   integer      seed = 32'h9c63;

   // the reference model queues expected items per output port in arrival order
   logic [64:0]  core_q[$];
   logic [32:0]  dram_q[$];
   logic [64:0]  mmio_q[$];
   logic [31:0]  mbox_q[$];
   logic [127:0] prof_model = '0;
   logic [31:0]  regs_model[3] = '{default: '0};
   logic         host_fired = 1'b0;
   logic [31:0]  host_expect_addr = '0;

   bp_zynq_bridge #(.mailbox_depth_p(mbox_depth)) u_dut (.*);

   always #20 clk_i = ~clk_i;

   task automatic report_failure(input string why);
      $display("%s at %0t ns", why, $time);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   // one request and its response on the host register port
   task automatic csr_access(input logic we, input logic [3:0] idx, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      csr_valid_i <= 1'b1;
      csr_we_i <= we;
      csr_idx_i <= idx;
      csr_wdata_i <= wdata;
      @(posedge clk_i);
      while (!csr_ready_o)
         @(posedge clk_i);
      csr_valid_i <= 1'b0;
      @(posedge clk_i);
      while (!(csr_rvalid_o && csr_rready_i))
         @(posedge clk_i);
      rdata = csr_rdata_o;
   endtask

   task automatic csr_write(input logic [3:0] idx, input logic [31:0] wdata);
      logic [31:0] rdata;
      csr_access(1'b1, idx, wdata, rdata);
      check_value("csr_rdata_o on write", rdata, 32'h0);
      if (idx < 4'd3)
         regs_model[idx[1:0]] = wdata;
      check_value("core_rst_n_o", core_rst_n_o, regs_model[0][0]);
   endtask

   task automatic csr_read_check(input logic [3:0] idx, input logic [31:0] exp);
      logic [31:0] rdata;
      csr_access(1'b0, idx, 32'h0, rdata);
      check_value($sformatf("csr_rdata_o[idx %0d]", idx), rdata, exp);
   endtask

   // with no traffic only the three writable registers hold anything
   function automatic logic [31:0] idle_read_value(input logic [3:0] idx);
      if (idx < 4'd3)
         return regs_model[idx[1:0]];
      return 32'h0;
   endfunction

   task automatic drive_host(input int count);
      logic [31:0] a;
      logic [31:0] d;
      for (int n = 0; n < count; n++)
      begin
         a = $random(seed);
         d = $random(seed);
         host_valid_i <= 1'b1;
         host_addr_i <= a[29:0];
         host_we_i <= a[30];
         host_wdata_i <= d;
         @(posedge clk_i);
         while (!host_ready_o)
            @(posedge clk_i);
         host_valid_i <= 1'b0;
         if (a[31])
            @(posedge clk_i);
      end
   endtask

   task automatic drive_dram(input int count);
      logic [31:0] a;
      logic [31:0] d;
      for (int n = 0; n < count; n++)
      begin
         a = $random(seed);
         d = $random(seed);
         dram_req_valid_i <= 1'b1;
         dram_req_addr_i <= a;
         dram_req_we_i <= d[0];
         @(posedge clk_i);
         while (!dram_req_ready_o)
            @(posedge clk_i);
         dram_req_valid_i <= 1'b0;
         if (d[1])
            @(posedge clk_i);
      end
   endtask

   task automatic drive_io(input int count);
      logic [31:0] a;
      for (int n = 0; n < count; n++)
      begin
         a = $random(seed);
         io_valid_i <= 1'b1;
         // about half the requests land below the mailbox split
         io_addr_i <= a[0] ? {11'h000, a[31:11]} : a;
         io_we_i <= a[1];
         io_wdata_i <= $random(seed);
         @(posedge clk_i);
         while (!io_ready_o)
            @(posedge clk_i);
         io_valid_i <= 1'b0;
      end
   endtask

   // random back-pressure on every response and output port
   always @(posedge clk_i)
   begin
      core_ready_i <= ($random(seed) & 3) != 0;
      dram_ready_i <= ($random(seed) & 3) != 0;
      mmio_ready_i <= ($random(seed) & 3) != 0;
      csr_rready_i <= ($random(seed) & 3) != 0;
   end

   always @(posedge clk_i)
   begin
      logic [64:0] item;
      // the page map restarts whenever the core sits in reset
      if (!core_rst_n_o)
         prof_model = '0;
      else if (dram_req_valid_i && dram_req_ready_o)
         prof_model[dram_req_addr_i[29:23]] = 1'b1;

      // a host item shows up on the core port exactly one cycle after it was taken
      if (host_fired)
      begin
         check_value("core_valid_o", core_valid_o, 32'h1);
         check_value("core_addr_o", core_addr_o, host_expect_addr);
      end
      if (core_valid_o && core_ready_i)
      begin
         if (core_q.size() == 0)
            report_failure("core port delivered a request that the host never sent");
         else
         begin
            item = core_q.pop_front();
            check_value("core_we_o", core_we_o, item[64]);
            check_value("core_addr_o", core_addr_o, item[63:32]);
            check_value("core_wdata_o", core_wdata_o, item[31:0]);
         end
      end
      host_fired = host_valid_i && host_ready_o;
      if (host_fired)
      begin
         // window bit 29 picks local space at 0 or cached DRAM at 0x8000_0000
         host_expect_addr = (host_addr_i[29] ? 32'h0000_0000 : 32'h8000_0000)
                            | {4'h0, host_addr_i[27:0]};
         core_q.push_back({host_we_i, host_expect_addr, host_wdata_i});
      end

      if (dram_valid_o && dram_ready_i)
      begin
         if (dram_q.size() == 0)
            report_failure("dram port delivered a request that the core never sent");
         else
         begin
            item = dram_q.pop_front();
            check_value("dram_we_o", dram_we_o, item[32]);
            check_value("dram_addr_o", dram_addr_o, item[31:0]);
         end
      end
      if (dram_req_valid_i && dram_req_ready_o)
         dram_q.push_back({dram_req_we_i, (dram_req_addr_i ^ 32'h8000_0000) + regs_model[2]});

      // a low write waits only for mailbox room, anything else waits for the MMIO side
      if (io_valid_i)
      begin
         if (io_we_i && io_addr_i < 32'h0020_0000)
            check_value("io_ready_o", io_ready_o, mbox_q.size() < mbox_depth);
         else
            check_value("io_ready_o", io_ready_o, mmio_ready_i);
      end

      // the MMIO port is combinational, so the item is queued before it is checked
      if (io_valid_i && io_ready_o)
      begin
         if (io_we_i && io_addr_i < 32'h0020_0000)
            mbox_q.push_back(io_wdata_i);
         else
            mmio_q.push_back({io_we_i, io_addr_i, io_wdata_i});
      end
      if (mmio_valid_o && mmio_ready_i)
      begin
         if (mmio_q.size() == 0)
            report_failure("mmio port delivered a request that belonged to the mailbox");
         else
         begin
            item = mmio_q.pop_front();
            check_value("mmio_we_o", mmio_we_o, item[64]);
            check_value("mmio_addr_o", mmio_addr_o, item[63:32]);
            check_value("mmio_wdata_o", mmio_wdata_o, item[31:0]);
         end
      end
   end

   initial
   begin
      #(timeout_ns);
      $display("watchdog expired before all transfers completed");
      $display("Testbench failed");
      $fatal(1);
   end

   initial
   begin
      logic [31:0] rnd;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      check_value("core_valid_o", core_valid_o, 32'h0);
      check_value("dram_valid_o", dram_valid_o, 32'h0);
      check_value("mmio_valid_o", mmio_valid_o, 32'h0);
      check_value("csr_rvalid_o", csr_rvalid_o, 32'h0);
      check_value("core_rst_n_o", core_rst_n_o, 32'h0);
      check_value("csr_ready_o", csr_ready_o, 32'h1);
      check_value("host_ready_o", host_ready_o, 32'h1);
      check_value("dram_req_ready_o", dram_req_ready_o, 32'h1);
      for (int i = 0; i < 3; i++)
         csr_read_check(4'(i), 32'h0);

      for (int n = 0; n < n_csr; n++)
      begin
         rnd = $random(seed);
         if (rnd[4])
            csr_write(rnd[3:0], $random(seed));
         else
            csr_read_check(rnd[3:0], idle_read_value(rnd[3:0]));
      end

      // run the core so the profiler records, then push host and DRAM traffic together
      csr_write(4'd0, 32'h1);
      csr_write(4'd2, $random(seed));
      fork
         drive_host(n_host);
         drive_dram(n_dram);
      join
      // the monitor records the last accepted request on this edge
      @(posedge clk_i);
      while (core_q.size() != 0 || dram_q.size() != 0)
         @(posedge clk_i);

      for (int w = 0; w < 4; w++)
         csr_read_check(4'(3 + w), prof_model[w*32 +: 32]);
      csr_write(4'd0, 32'h0);
      csr_write(4'd0, 32'h1);
      for (int w = 0; w < 4; w++)
         csr_read_check(4'(3 + w), 32'h0);

      for (int r = 0; r < n_io_rounds; r++)
      begin
         drive_io(mbox_depth);
         @(posedge clk_i);
         csr_read_check(4'd7, 32'(mbox_q.size()));
         while (mbox_q.size() != 0)
            csr_read_check(4'd8, mbox_q.pop_front());
         csr_read_check(4'd8, 32'h0);
         csr_read_check(4'd7, 32'h0);
      end

      if (mmio_q.size() != 0)
         report_failure("mmio port never delivered every routed request");
      else
      begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

// ==== src.f ====
rtl/zynq_addr_pkg.sv
rtl/zynq_csr_pkg.sv
rtl/zynq_csr_bank.sv
rtl/host_addr_xlate.sv
rtl/dram_addr_xlate.sv
rtl/mem_profiler.sv
rtl/core_io_router.sv
rtl/bp_zynq_bridge.sv
dv/tb_bp_zynq_bridge.sv

// ==== Makefile ====
TOP := tb_bp_zynq_bridge

.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
